/* rtl/congrue_pkg.sv */
`default_nettype none

package congrue_pkg;

    ////////////////////////////////////////////////////////////
    // Table geometry
    ////////////////////////////////////////////////////////////

    // Records held by the table
    localparam int NUM_ENTRIES = 16;

    // Bits needed to name one slot
    localparam int SLOT_W = 4;

    // Width of every numeric record field
    localparam int BYTE_W = 8;

    ////////////////////////////////////////////////////////////
    // Record and command layouts
    ////////////////////////////////////////////////////////////

    // One array-descriptor record, array part first
    typedef struct packed {
        logic              arr_def;
        logic [BYTE_W-1:0] array_code;
        logic              elt_def;
        logic [BYTE_W-1:0] rank;
        logic [BYTE_W-1:0] low;
        logic [BYTE_W-1:0] high;
        logic [BYTE_W-1:0] index;
        logic [BYTE_W-1:0] value;
        logic              mark;
    } entry_t;

    // Parameters of one congruence-up sweep
    typedef struct packed {
        logic [BYTE_W-1:0] new_index;
        logic [BYTE_W-1:0] new_value;
        logic [BYTE_W-1:0] metadata;
        logic              is_metadata;
    } congrue_cmd_t;

endpackage

`default_nettype wire

/* rtl/congrue_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

module congrue_sweep import congrue_pkg::*; (
    input  logic               clk,
    input  logic               rst,

    // Sweep request from the host
    input  logic               start,
    input  congrue_cmd_t       cmd,

    // Host write strobe, watched only
    input  logic               host_wr_en,

    output logic               busy,
    output logic               done,

    // Current slot and its write-back strobe
    output logic [SLOT_W-1:0]  slot,
    output logic               sweep_wr_en,

    // Command held for the whole sweep
    output congrue_cmd_t       active_cmd
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;
    logic   last_slot;

    assign busy        = (state == ST_BUSY);
    // Every busy cycle writes one slot back
    assign sweep_wr_en = busy;
    assign last_slot   = (slot == SLOT_W'(NUM_ENTRIES - 1));

    ////////////////////////////////////////////////////////////
    // Control FSM and slot counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            slot  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_BUSY;
                        slot  <= '0;
                    end
                end
                ST_BUSY: begin
                    // start is ignored here
                    if (last_slot) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                    slot <= slot + 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command capture, only when a start is accepted
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            active_cmd <= cmd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Host must stay off the table for the whole sweep
    a_no_host_write: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> !host_wr_en
    ) else $error("congrue_sweep: host write during a sweep");

    // done comes after the sweep, never inside it
    a_done_after_busy: assert property (
        @(posedge clk) disable iff (rst)
        done |-> (!busy && $past(busy))
    ) else $error("congrue_sweep: done outside the end of a sweep");

endmodule

`default_nettype wire

/* rtl/congrue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module congrue_top import congrue_pkg::*; (
    input  logic               clk,
    input  logic               rst,

    // Host record access
    input  logic               wr_en,
    input  logic [SLOT_W-1:0]  wr_addr,
    input  entry_t             wr_entry,
    input  logic [SLOT_W-1:0]  rd_addr,
    output entry_t             rd_entry,

    // Sweep control
    input  logic               start,
    input  congrue_cmd_t       cmd,
    output logic               busy,
    output logic               done
);

    logic [SLOT_W-1:0] slot;
    logic              sweep_wr_en;
    congrue_cmd_t      active_cmd;
    entry_t            sweep_rd_entry;
    entry_t            sweep_wr_entry;

    entry_table entry_table_inst (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_entry       (wr_entry),
        .sweep_wr_en    (sweep_wr_en),
        .sweep_addr     (slot),
        .sweep_wr_entry (sweep_wr_entry),
        .rd_addr        (rd_addr),
        .rd_entry       (rd_entry),
        .sweep_rd_entry (sweep_rd_entry)
    );

    congrue_sweep congrue_sweep_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd         (cmd),
        .host_wr_en  (wr_en),
        .busy        (busy),
        .done        (done),
        .slot        (slot),
        .sweep_wr_en (sweep_wr_en),
        .active_cmd  (active_cmd)
    );

    // Slot number doubles as the record handle
    congrue_up_update congrue_up_update_inst (
        .entry   (sweep_rd_entry),
        .handle  (slot),
        .cmd     (active_cmd),
        .updated (sweep_wr_entry)
    );

endmodule

`default_nettype wire

/* rtl/congrue_up_update.sv */
`timescale 1ns/1ps
`default_nettype none

module congrue_up_update import congrue_pkg::*; (
    input  entry_t             entry,
    input  logic [SLOT_W-1:0]  handle,
    input  congrue_cmd_t       cmd,
    output entry_t             updated
);

    ////////////////////////////////////////////////////////////
    // Decode of the command against this slot
    ////////////////////////////////////////////////////////////

    // Slot number widened to field width
    logic [BYTE_W-1:0] handle_w;
    logic              hit;

    // Values written into a re-initialized record
    logic [BYTE_W-1:0] reinit_bound;
    logic [BYTE_W-1:0] reinit_rank;

    // Shift conditions for the other records
    logic inc_code;
    logic inc_low;
    logic inc_high;

    assign handle_w = {{(BYTE_W-SLOT_W){1'b0}}, handle};
    assign hit      = (cmd.new_index == handle_w);

    // All three bounds share one value on insertion
    assign reinit_bound = cmd.is_metadata ? (cmd.metadata + 8'd1) : handle_w;
    assign reinit_rank  = cmd.is_metadata ? (cmd.new_value + 8'd1) : 8'd1;

    // Codes strictly above the inserted metadata move up by one
    assign inc_code = entry.arr_def && cmd.is_metadata &&
                      (entry.array_code > cmd.metadata);
    assign inc_low  = entry.elt_def && cmd.is_metadata &&
                      (entry.low > cmd.metadata);
    // high also moves when it sits exactly on the metadata
    assign inc_high = entry.elt_def && cmd.is_metadata &&
                      (entry.high >= cmd.metadata);

    ////////////////////////////////////////////////////////////
    // Record rewrite
    ////////////////////////////////////////////////////////////

    always_comb begin
        updated = entry;
        if (hit) begin
            updated.array_code = reinit_bound;
            updated.rank       = reinit_rank;
            updated.low        = reinit_bound;
            updated.high       = reinit_bound;
        end else begin
            // 8-bit wrap on increment, 255 goes to 0
            if (inc_code) begin
                updated.array_code = entry.array_code + 8'd1;
            end
            if (inc_low) begin
                updated.low = entry.low + 8'd1;
            end
            if (inc_high) begin
                updated.high = entry.high + 8'd1;
            end
        end
        // Mark always drops after the step
        updated.mark = 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

module entry_table import congrue_pkg::*; (
    input  logic               clk,
    input  logic               rst,

    // Host write port
    input  logic               wr_en,
    input  logic [SLOT_W-1:0]  wr_addr,
    input  entry_t             wr_entry,

    // Sweep write port
    input  logic               sweep_wr_en,
    input  logic [SLOT_W-1:0]  sweep_addr,
    input  entry_t             sweep_wr_entry,

    // Host read port
    input  logic [SLOT_W-1:0]  rd_addr,
    output entry_t             rd_entry,

    // Sweep read port, same address as the sweep write
    output entry_t             sweep_rd_entry
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    entry_t entries [NUM_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_addr] <= wr_entry;
        end else if (sweep_wr_en) begin
            // Read-modify-write of the current sweep slot
            entries[sweep_addr] <= sweep_wr_entry;
        end
    end

    ////////////////////////////////////////////////////////////
    // Asynchronous reads
    ////////////////////////////////////////////////////////////

    assign rd_entry       = entries[rd_addr];
    assign sweep_rd_entry = entries[sweep_addr];

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Host and sweep never compete for the write port;
    // the sweep would silently lose its write-back
    a_single_writer: assert property (
        @(posedge clk) disable iff (rst)
        !(wr_en && sweep_wr_en)
    ) else $error("entry_table: host and sweep write in the same cycle");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=congrue_tb

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module "$TOP" -o sim_bin
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

/* src.f */
+incdir+tests
rtl/congrue_pkg.sv
rtl/congrue_up_update.sv
rtl/entry_table.sv
rtl/congrue_sweep.sv
rtl/congrue_top.sv
tests/congrue_tb.sv

/* tests/congrue_model.svh */
`ifndef CONGRUE_MODEL_SVH
`define CONGRUE_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference copy of the record table
////////////////////////////////////////////////////////////

entry_t model_mem [NUM_ENTRIES];

// 8-bit increment, 255 wraps to 0
function automatic logic [7:0] add_one(input logic [7:0] v);
    int sum;
    sum = (int'(v) + 1) % 256;
    return sum[7:0];
endfunction

// One record after the congruence-up step at this slot
function automatic entry_t model_step(input entry_t e, input int slot,
                                      input congrue_cmd_t c);
    entry_t r;
    logic [7:0] bound;
    r = e;
    if (int'(c.new_index) == slot) begin
        // Newly inserted element
        bound = c.is_metadata ? add_one(c.metadata) : 8'(slot);
        r.array_code = bound;
        r.low = bound;
        r.high = bound;
        r.rank = c.is_metadata ? add_one(c.new_value) : 8'd1;
    end else if (c.is_metadata) begin
        if (e.arr_def && (e.array_code > c.metadata))
            r.array_code = add_one(e.array_code);
        if (e.elt_def && (e.low > c.metadata))
            r.low = add_one(e.low);
        if (e.elt_def && (e.high >= c.metadata))
            r.high = add_one(e.high);
    end
    r.mark = 1'b0;
    return r;
endfunction

////////////////////////////////////////////////////////////
// Table level operations
////////////////////////////////////////////////////////////

function automatic void model_clear();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        model_mem[i] = '0;
    end
endfunction

function automatic void model_sweep(input congrue_cmd_t c);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
        model_mem[i] = model_step(model_mem[i], i, c);
    end
endfunction

`endif

/* tests/congrue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module congrue_tb import congrue_pkg::*; ();

    logic              clk;
    logic              rst;
    logic              wr_en;
    logic [SLOT_W-1:0] wr_addr;
    entry_t            wr_entry;
    logic [SLOT_W-1:0] rd_addr;
    entry_t            rd_entry;
    logic              start;
    congrue_cmd_t      cmd;
    logic              busy;
    logic              done;

    int          err_count;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_state;
    entry_t      loaded [NUM_ENTRIES];

    `include "congrue_model.svh"

    congrue_top congrue_top_inst (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_entry (wr_entry),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry),
        .start    (start),
        .cmd      (cmd),
        .busy     (busy),
        .done     (done)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic entry_t random_entry();
        entry_t e;
        e.arr_def    = 1'(rand_bits(1));
        e.array_code = 8'(rand_bits(8));
        e.elt_def    = 1'(rand_bits(1));
        e.rank       = 8'(rand_bits(8));
        e.low        = 8'(rand_bits(8));
        e.high       = 8'(rand_bits(8));
        e.index      = 8'(rand_bits(8));
        e.value      = 8'(rand_bits(8));
        e.mark       = 1'(rand_bits(1));
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // Host side helpers
    ////////////////////////////////////////////////////////////

    // Every drive happens half a ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    // Reset held for five cycles, model follows
    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) next_cycle();
        rst = 1'b0;
        model_clear();
    endtask

    task automatic check(input string name, input logic [63:0] got,
                         input logic [63:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h",
                     $time, name, got, expected);
            err_count++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic write_entry(input int addr, input entry_t e);
        wr_en    = 1'b1;
        wr_addr  = SLOT_W'(addr);
        wr_entry = e;
        next_cycle();
        wr_en = 1'b0;
        model_mem[addr] = e;
        loaded[addr] = e;
    endtask

    task automatic load_all_random(input logic force_mark);
        entry_t e;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = random_entry();
            if (force_mark)
                e.mark = 1'b1;
            write_entry(i, e);
        end
    endtask

    task automatic compare_table();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            rd_addr = SLOT_W'(i);
            #1;
            check($sformatf("rd_entry[%0d]", i), 64'(rd_entry), 64'(model_mem[i]));
            next_cycle();
        end
    endtask

    // Second start goes out in busy cycle extra_at (0 for none)
    task automatic run_sweep(input congrue_cmd_t c, input int extra_at,
                             output int cycles);
        int   limit;
        logic seen_done;
        limit     = 4 * NUM_ENTRIES;
        seen_done = 1'b0;
        cycles    = 0;
        cmd       = c;
        start     = 1'b1;
        while (!seen_done && cycles < limit) begin
            next_cycle();
            cycles++;
            start = (cycles == extra_at);
            cmd   = start ? congrue_cmd_t'(~c) : c;
            seen_done = done;
            if (!seen_done)
                check($sformatf("busy in sweep cycle %0d", cycles), 64'(busy), 64'(1));
        end
        start = 1'b0;
        if (!seen_done) begin
            $display("Timeout: done did not pulse within %0d cycles of start", limit);
            err_count++;
        end else begin
            check("busy at done", 64'(busy), 64'(0));
        end
        model_sweep(c);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int           errs;
        int           cycles;
        congrue_cmd_t c;
        entry_t       e;

        clk = 1'b0;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_entry = '0;
        rd_addr = '0;
        start = 1'b0;
        cmd = '0;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        lfsr_state = 32'hdb958419;

        apply_reset();

        // Fill the table and leave a sweep running, then reset again
        errs = err_count;
        load_all_random(1'b1);
        cmd   = 25'(rand_bits(25));
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        next_cycle();
        apply_reset();
        check("busy", 64'(busy), 64'(0));
        check("done", 64'(done), 64'(0));
        compare_table();
        end_test("reset state", errs);

        errs = err_count;
        load_all_random(1'b0);
        compare_table();
        end_test("write and read back", errs);

        // Slot 1 sits at 255 to force a wrap and slot 2 sits on the metadata
        errs = err_count;
        // Insertion kept away from slots 1 and 2
        c.new_index   = 8'(rand_bits(4)) | 8'h4;
        c.new_value   = 8'(rand_bits(8));
        c.metadata    = {1'b0, 7'(rand_bits(7))};
        c.is_metadata = 1'b1;
        e = random_entry();
        e.arr_def = 1'b1;
        e.elt_def = 1'b1;
        e.array_code = 8'hff;
        e.low = 8'hff;
        e.high = 8'hff;
        write_entry(1, e);
        e.array_code = c.metadata;
        e.low = c.metadata;
        e.high = c.metadata;
        write_entry(2, e);
        run_sweep(c, 0, cycles);
        compare_table();
        end_test("sweep with metadata", errs);

        errs = err_count;
        c.new_index   = 8'(rand_bits(4));
        c.new_value   = 8'(rand_bits(8));
        c.metadata    = 8'(rand_bits(8));
        c.is_metadata = 1'b0;
        run_sweep(c, 0, cycles);
        compare_table();
        rd_addr = SLOT_W'(c.new_index);
        #1;
        check("reinit array_code", 64'(rd_entry.array_code), 64'(c.new_index));
        check("reinit rank", 64'(rd_entry.rank), 64'(1));
        next_cycle();
        // Index beyond the table leaves every slot alone
        c.new_index = 8'h10 | 8'(rand_bits(8));
        run_sweep(c, 0, cycles);
        compare_table();
        end_test("sweep without metadata", errs);

        errs = err_count;
        c.new_index   = 8'(rand_bits(4));
        c.new_value   = 8'(rand_bits(8));
        c.metadata    = 8'(rand_bits(8));
        c.is_metadata = 1'b1;
        run_sweep(c, 5, cycles);
        check("cycles to done", 64'(cycles), 64'(NUM_ENTRIES + 1));
        next_cycle();
        check("done after pulse", 64'(done), 64'(0));
        check("busy after done", 64'(busy), 64'(0));
        compare_table();
        end_test("sweep timing", errs);

        errs = err_count;
        load_all_random(1'b1);
        c.new_index   = 8'(rand_bits(8));
        c.new_value   = 8'(rand_bits(8));
        c.metadata    = 8'(rand_bits(8));
        c.is_metadata = 1'(rand_bits(1));
        run_sweep(c, 0, cycles);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            rd_addr = SLOT_W'(i);
            #1;
            check($sformatf("mark[%0d]", i), 64'(rd_entry.mark), 64'(0));
            check($sformatf("index[%0d]", i), 64'(rd_entry.index), 64'(loaded[i].index));
            check($sformatf("value[%0d]", i), 64'(rd_entry.value), 64'(loaded[i].value));
            next_cycle();
        end
        compare_table();
        end_test("marks and payload", errs);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
